// File: hw/riscv_dec_consts.svh
`ifndef RISCV_DEC_CONSTS_SVH
`define RISCV_DEC_CONSTS_SVH

`define XLEN 32

// Major opcodes, bits 6:0.
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP_IMM   7'b0010011
`define OPC_OP       7'b0110011
`define OPC_MISC_MEM 7'b0001111
`define OPC_SYSTEM   7'b1110011

`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SR      3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LBU 3'b100
`define F3_LHU 3'b101
`define F3_SB  3'b000
`define F3_SH  3'b001
`define F3_SW  3'b010

`define F3_JALR  3'b000
`define F3_FENCE 3'b000
`define F3_PRIV  3'b000

`define F3_CSRRW  3'b001
`define F3_CSRRS  3'b010
`define F3_CSRRC  3'b011
`define F3_CSRRWI 3'b101
`define F3_CSRRSI 3'b110
`define F3_CSRRCI 3'b111

`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

`define INST_ECALL  32'h00000073
`define INST_EBREAK 32'h00100073
`define INST_MRET   32'h30200073
`define INST_WFI    32'h10500073

`endif

// File: hw/riscv_dec_pkg.sv
package riscv_dec_pkg;

	typedef logic [31:0] inst_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [11:0] csr_addr_t;

	// Zero is ALU_ADD, so an idle stage presents a plain add.
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
		ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
		ALU_OR, ALU_AND, ALU_SEQ, ALU_SNE,
		ALU_SGE, ALU_SGEU, ALU_INC
	} alu_op_t;

	// The nine memory operations need four bits.
	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU,
		MEM_LHU, MEM_SB, MEM_SH, MEM_SW
	} mem_op_t;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_CSR
	} wb_src_t;

	typedef enum logic [1:0] {
		CSR_NONE, CSR_RW, CSR_RS, CSR_RC
	} csr_op_t;

	// IMM_Z is the 5-bit unsigned CSR immediate.
	typedef enum logic [2:0] {
		IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_Z
	} imm_sel_t;

endpackage

// File: hw/decode_ctrl.sv
`timescale 1ns/1ps
`include "riscv_dec_consts.svh"

module decode_ctrl
	import riscv_dec_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      inst_valid,
	input  inst_t     inst,
	output imm_sel_t  imm_sel,
	output csr_op_t   csr_cmd,
	output logic      dec_valid,
	output logic      rs1_rena,
	output logic      rs2_rena,
	output logic      rd_wena,
	output logic      sel_pc,
	output logic      sel_im,
	output logic      jump_ena,
	output logic      jump_ind,
	output logic      jump_alw,
	output logic      env_call,
	output logic      trap_ret,
	output logic      illegal_inst,
	output reg_addr_t rs1_addr,
	output reg_addr_t rs2_addr,
	output reg_addr_t rd_addr,
	output alu_op_t   alu_op,
	output mem_op_t   mem_op,
	output wb_src_t   wb_src
);

	// All-zero is the idle value of every field.
	typedef struct packed {
		logic    dec_valid;
		logic    rs1_rena;
		logic    rs2_rena;
		logic    rd_wena;
		logic    sel_pc;
		logic    sel_im;
		logic    jump_ena;
		logic    jump_ind;
		logic    jump_alw;
		logic    env_call;
		logic    trap_ret;
		logic    illegal_inst;
		alu_op_t alu_op;
		mem_op_t mem_op;
		wb_src_t wb_src;
	} ctrl_t;

	ctrl_t      ctrl_d;
	ctrl_t      ctrl_q;
	logic       known;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// Shared by the register and the immediate ALU forms.
	function automatic alu_op_t alu_of(input logic [2:0] f3, input logic alt);
		case (f3)
			`F3_ADD_SUB: alu_of = alt ? ALU_SUB : ALU_ADD;
			`F3_SLL:     alu_of = ALU_SLL;
			`F3_SLT:     alu_of = ALU_SLT;
			`F3_SLTU:    alu_of = ALU_SLTU;
			`F3_XOR:     alu_of = ALU_XOR;
			`F3_SR:      alu_of = alt ? ALU_SRA : ALU_SRL;
			`F3_OR:      alu_of = ALU_OR;
			`F3_AND:     alu_of = ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl_d  = '0;
		imm_sel = IMM_NONE;
		csr_cmd = CSR_NONE;
		known   = 1'b1;
		case (opcode)
			`OPC_LUI, `OPC_AUIPC: begin
				ctrl_d.rd_wena = 1'b1;
				ctrl_d.sel_im  = 1'b1;
				ctrl_d.sel_pc  = (opcode == `OPC_AUIPC); // AUIPC adds the PC.
				imm_sel        = IMM_U;
			end
			`OPC_JAL, `OPC_JALR: begin
				ctrl_d.rd_wena  = 1'b1;
				ctrl_d.sel_pc   = 1'b1;
				ctrl_d.alu_op   = ALU_INC; // The link value is PC plus four.
				ctrl_d.jump_ena = 1'b1;
				ctrl_d.jump_alw = 1'b1;
				imm_sel         = IMM_J;
				if (opcode == `OPC_JALR) begin
					known           = (funct3 == `F3_JALR);
					ctrl_d.rs1_rena = 1'b1;
					ctrl_d.jump_ind = 1'b1;
					imm_sel         = IMM_I;
				end
			end
			`OPC_BRANCH: begin
				ctrl_d.rs1_rena = 1'b1;
				ctrl_d.rs2_rena = 1'b1;
				ctrl_d.jump_ena = 1'b1;
				imm_sel         = IMM_B;
				case (funct3)
					`F3_BEQ:  ctrl_d.alu_op = ALU_SEQ;
					`F3_BNE:  ctrl_d.alu_op = ALU_SNE;
					`F3_BLT:  ctrl_d.alu_op = ALU_SLT;
					`F3_BGE:  ctrl_d.alu_op = ALU_SGE;
					`F3_BLTU: ctrl_d.alu_op = ALU_SLTU;
					`F3_BGEU: ctrl_d.alu_op = ALU_SGEU;
					default:  known = 1'b0;
				endcase
			end
			`OPC_LOAD, `OPC_STORE: begin
				ctrl_d.rs1_rena = 1'b1;
				ctrl_d.sel_im   = 1'b1;
				ctrl_d.wb_src   = WB_MEM;
				if (opcode == `OPC_LOAD) begin
					ctrl_d.rd_wena = 1'b1;
					imm_sel        = IMM_I;
					case (funct3)
						`F3_LB:  ctrl_d.mem_op = MEM_LB;
						`F3_LH:  ctrl_d.mem_op = MEM_LH;
						`F3_LW:  ctrl_d.mem_op = MEM_LW;
						`F3_LBU: ctrl_d.mem_op = MEM_LBU;
						`F3_LHU: ctrl_d.mem_op = MEM_LHU;
						default: known = 1'b0;
					endcase
				end else begin
					ctrl_d.rs2_rena = 1'b1;
					imm_sel         = IMM_S;
					case (funct3)
						`F3_SB:  ctrl_d.mem_op = MEM_SB;
						`F3_SH:  ctrl_d.mem_op = MEM_SH;
						`F3_SW:  ctrl_d.mem_op = MEM_SW;
						default: known = 1'b0;
					endcase
				end
			end
			`OPC_OP_IMM: begin
				ctrl_d.rs1_rena = 1'b1;
				ctrl_d.rd_wena  = 1'b1;
				ctrl_d.sel_im   = 1'b1;
				ctrl_d.alu_op   = alu_of(funct3, inst[30] && funct3 == `F3_SR);
				imm_sel         = IMM_I;
				// Shift immediates carry a funct7 that has to be valid.
				if (funct3 == `F3_SLL)
					known = (funct7 == `F7_BASE);
				else if (funct3 == `F3_SR)
					known = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
			end
			`OPC_OP: begin
				ctrl_d.rs1_rena = 1'b1;
				ctrl_d.rs2_rena = 1'b1;
				ctrl_d.rd_wena  = 1'b1;
				ctrl_d.alu_op   = alu_of(funct3, inst[30]);
				known = (funct7 == `F7_BASE) || (funct7 == `F7_ALT &&
					(funct3 == `F3_ADD_SUB || funct3 == `F3_SR));
			end
			`OPC_MISC_MEM: known = (funct3 == `F3_FENCE); // FENCE has no effect here.
			`OPC_SYSTEM: begin
				if (funct3 == `F3_PRIV) begin
					case (inst)
						`INST_ECALL: ctrl_d.env_call = 1'b1;
						`INST_MRET: begin
							ctrl_d.jump_ena = 1'b1;
							ctrl_d.jump_alw = 1'b1;
							ctrl_d.trap_ret = 1'b1;
						end
						`INST_WFI:    ;
						`INST_EBREAK: known = 1'b0; // Not supported, so it traps.
						default:      known = 1'b0;
					endcase
				end else begin
					ctrl_d.rd_wena  = 1'b1;
					ctrl_d.wb_src   = WB_CSR;
					ctrl_d.rs1_rena = ~funct3[2];
					ctrl_d.sel_im   = funct3[2];
					imm_sel         = funct3[2] ? IMM_Z : IMM_NONE;
					case (funct3)
						`F3_CSRRW, `F3_CSRRWI: csr_cmd = CSR_RW;
						`F3_CSRRS, `F3_CSRRSI: csr_cmd = CSR_RS;
						`F3_CSRRC, `F3_CSRRCI: csr_cmd = CSR_RC;
						default:               known = 1'b0;
					endcase
				end
			end
			default: known = 1'b0;
		endcase

		// An empty slot or an unknown word must leave every other output idle.
		if (!inst_valid || !known) begin
			ctrl_d  = '0;
			imm_sel = IMM_NONE;
			csr_cmd = CSR_NONE;
		end
		ctrl_d.dec_valid    = inst_valid;
		ctrl_d.illegal_inst = inst_valid && !known;
	end

	always_ff @(posedge clk) begin
		if (rst)
			ctrl_q <= '0;
		else
			ctrl_q <= ctrl_d;
	end

	always_ff @(posedge clk) begin
		rs1_addr <= inst[19:15];
		rs2_addr <= inst[24:20];
		rd_addr  <= inst[11:7];
	end

	assign dec_valid    = ctrl_q.dec_valid;
	assign rs1_rena     = ctrl_q.rs1_rena;
	assign rs2_rena     = ctrl_q.rs2_rena;
	assign rd_wena      = ctrl_q.rd_wena;
	assign sel_pc       = ctrl_q.sel_pc;
	assign sel_im       = ctrl_q.sel_im;
	assign jump_ena     = ctrl_q.jump_ena;
	assign jump_ind     = ctrl_q.jump_ind;
	assign jump_alw     = ctrl_q.jump_alw;
	assign env_call     = ctrl_q.env_call;
	assign trap_ret     = ctrl_q.trap_ret;
	assign illegal_inst = ctrl_q.illegal_inst;
	assign alu_op       = ctrl_q.alu_op;
	assign mem_op       = ctrl_q.mem_op;
	assign wb_src       = ctrl_q.wb_src;

endmodule

// File: hw/imm_gen.sv
`timescale 1ns/1ps
`include "riscv_dec_consts.svh"

module imm_gen
	import riscv_dec_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  inst_t    inst,
	input  imm_sel_t imm_sel,
	output word_t    immediate
);

	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	word_t imm_z;
	word_t imm_next;

	assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_z = {{(`XLEN-5){1'b0}}, inst[19:15]}; // The uimm shares the rs1 field.

	always_comb begin
		case (imm_sel)
			IMM_I:   imm_next = imm_i;
			IMM_S:   imm_next = imm_s;
			IMM_B:   imm_next = imm_b;
			IMM_U:   imm_next = imm_u;
			IMM_J:   imm_next = imm_j;
			IMM_Z:   imm_next = imm_z;
			default: imm_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			immediate <= '0;
		else
			immediate <= imm_next;
	end

endmodule

// File: hw/csr_access.sv
`timescale 1ns/1ps

module csr_access
	import riscv_dec_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  inst_t     inst,
	input  csr_op_t   csr_cmd,
	output csr_addr_t csr_addr,
	output csr_op_t   csr_op,
	output logic      csr_rena,
	output logic      csr_wena
);

	logic rd_nz;
	logic src_nz;
	logic rena_next;
	logic wena_next;

	assign rd_nz  = |inst[11:7];
	assign src_nz = |inst[19:15]; // The rs1 field and the uimm share these bits.

	// A swap with rd zero skips the read; set and clear with a zero source skip the write.
	always_comb begin
		rena_next = 1'b0;
		wena_next = 1'b0;
		case (csr_cmd)
			CSR_RW: begin
				rena_next = rd_nz;
				wena_next = 1'b1;
			end
			CSR_RS, CSR_RC: begin
				rena_next = 1'b1;
				wena_next = src_nz;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			csr_op   <= CSR_NONE;
			csr_rena <= 1'b0;
			csr_wena <= 1'b0;
		end else begin
			csr_op   <= csr_cmd;
			csr_rena <= rena_next;
			csr_wena <= wena_next;
		end
	end

	always_ff @(posedge clk)
		csr_addr <= inst[31:20];

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
	import riscv_dec_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      inst_valid,
	input  inst_t     inst,
	output logic      dec_valid,
	output word_t     immediate,
	output logic      rs1_rena,
	output reg_addr_t rs1_addr,
	output logic      rs2_rena,
	output reg_addr_t rs2_addr,
	output logic      rd_wena,
	output reg_addr_t rd_addr,
	output csr_addr_t csr_addr,
	output logic      csr_rena,
	output logic      csr_wena,
	output logic      sel_pc,
	output logic      sel_im,
	output wb_src_t   wb_src,
	output alu_op_t   alu_op,
	output mem_op_t   mem_op,
	output csr_op_t   csr_op,
	output logic      jump_ena,
	output logic      jump_ind,
	output logic      jump_alw,
	output logic      env_call,
	output logic      trap_ret,
	output logic      illegal_inst
);

	imm_sel_t imm_sel;
	csr_op_t  csr_cmd;

	decode_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.imm_sel      (imm_sel),
		.csr_cmd      (csr_cmd),
		.dec_valid    (dec_valid),
		.rs1_rena     (rs1_rena),
		.rs2_rena     (rs2_rena),
		.rd_wena      (rd_wena),
		.sel_pc       (sel_pc),
		.sel_im       (sel_im),
		.jump_ena     (jump_ena),
		.jump_ind     (jump_ind),
		.jump_alw     (jump_alw),
		.env_call     (env_call),
		.trap_ret     (trap_ret),
		.illegal_inst (illegal_inst),
		.rs1_addr     (rs1_addr),
		.rs2_addr     (rs2_addr),
		.rd_addr      (rd_addr),
		.alu_op       (alu_op),
		.mem_op       (mem_op),
		.wb_src       (wb_src)
	);

	imm_gen u_imm (
		.clk       (clk),
		.rst       (rst),
		.inst      (inst),
		.imm_sel   (imm_sel),
		.immediate (immediate)
	);

	csr_access u_csr (
		.clk      (clk),
		.rst      (rst),
		.inst     (inst),
		.csr_cmd  (csr_cmd),
		.csr_addr (csr_addr),
		.csr_op   (csr_op),
		.csr_rena (csr_rena),
		.csr_wena (csr_wena)
	);

endmodule

// File: testbench/inst_decoder_asserts.sv
`timescale 1ns/1ps

module inst_decoder_asserts (
	input logic clk,
	input logic rst,
	input logic inst_valid,
	input logic dec_valid,
	input logic jump_ena,
	input logic jump_alw,
	input logic illegal_inst,
	input logic rd_wena,
	input logic csr_wena
);

	// One cycle of latency, never more and never less.
	valid_follows: assert property (@(posedge clk) disable iff (rst)
		dec_valid == $past(inst_valid))
		else $error("dec_valid differs from inst_valid of the previous cycle");

	always_jumps: assert property (@(posedge clk) disable iff (rst)
		jump_alw |-> jump_ena)
		else $error("jump_alw is set without jump_ena");

	illegal_quiet: assert property (@(posedge clk) disable iff (rst)
		illegal_inst |-> !rd_wena && !csr_wena)
		else $error("an illegal instruction enables a register or CSR write");

endmodule

bind inst_decoder inst_decoder_asserts u_asserts (
	.clk          (clk),
	.rst          (rst),
	.inst_valid   (inst_valid),
	.dec_valid    (dec_valid),
	.jump_ena     (jump_ena),
	.jump_alw     (jump_alw),
	.illegal_inst (illegal_inst),
	.rd_wena      (rd_wena),
	.csr_wena     (csr_wena)
);

// File: testbench/tb_inst_decoder.sv
`timescale 1ns/1ps
`include "riscv_dec_consts.svh"

module tb_inst_decoder
	import riscv_dec_pkg::*;
();

	localparam int MAX_CYCLES = 400; // The tests take under 100 cycles.

	// Expected response of one pipeline slot.
	typedef struct packed {
		logic      valid;
		logic      rs1_rena;
		logic      rs2_rena;
		logic      rd_wena;
		logic      sel_pc;
		logic      sel_im;
		logic      jump_ena;
		logic      jump_ind;
		logic      jump_alw;
		logic      env_call;
		logic      trap_ret;
		logic      illegal;
		alu_op_t   alu;
		mem_op_t   mem;
		wb_src_t   wb;
		word_t     imm;
		csr_addr_t csr_addr;
		csr_op_t   csr_op;
		logic      csr_rena;
		logic      csr_wena;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
	} exp_t;

	logic      clk = 1'b0;
	logic      rst;
	logic      inst_valid;
	inst_t     inst;
	logic      dec_valid;
	word_t     immediate;
	logic      rs1_rena;
	reg_addr_t rs1_addr;
	logic      rs2_rena;
	reg_addr_t rs2_addr;
	logic      rd_wena;
	reg_addr_t rd_addr;
	csr_addr_t csr_addr;
	logic      csr_rena;
	logic      csr_wena;
	logic      sel_pc;
	logic      sel_im;
	wb_src_t   wb_src;
	alu_op_t   alu_op;
	mem_op_t   mem_op;
	csr_op_t   csr_op;
	logic      jump_ena;
	logic      jump_ind;
	logic      jump_alw;
	logic      env_call;
	logic      trap_ret;
	logic      illegal_inst;
	integer    seed = 32'h349f;
	int        cycles = 0;
	exp_t      prev;
	string     prev_tag;

	inst_decoder DUT (.*);

	always #5 clk = ~clk;

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic mismatch(input string tag, input string msg);
		abort_run($sformatf("FAILED at %0t: %s: %s", $time, tag, msg));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
			abort_run($sformatf("Timeout: the run did not end within %0d cycles", MAX_CYCLES));
	end

	// Flag order is valid, rs1, rs2, rd, pc, im, jena, jind, jalw, ecall, tret, illegal.
	task automatic check_ctrl(input string tag, input alu_op_t alu, input mem_op_t mem,
			input wb_src_t wb, input logic [11:0] flags);
		logic [11:0] got;
		got = {dec_valid, rs1_rena, rs2_rena, rd_wena, sel_pc, sel_im,
			jump_ena, jump_ind, jump_alw, env_call, trap_ret, illegal_inst};
		if (got !== flags)
			mismatch(tag, $sformatf("flags %b, expected %b", got, flags));
		if (alu_op !== alu)
			mismatch(tag, $sformatf("alu_op %s, expected %s", alu_op.name(), alu.name()));
		if (mem_op !== mem)
			mismatch(tag, $sformatf("mem_op %s, expected %s", mem_op.name(), mem.name()));
		if (wb_src !== wb)
			mismatch(tag, $sformatf("wb_src %s, expected %s", wb_src.name(), wb.name()));
	endtask

	task automatic check_regs(input string tag, input reg_addr_t rs1, input reg_addr_t rs2,
			input reg_addr_t rd, input logic [2:0] ena);
		if (ena[2] && rs1_addr !== rs1)
			mismatch(tag, $sformatf("rs1_addr %0d, expected %0d", rs1_addr, rs1));
		if (ena[1] && rs2_addr !== rs2)
			mismatch(tag, $sformatf("rs2_addr %0d, expected %0d", rs2_addr, rs2));
		if (ena[0] && rd_addr !== rd)
			mismatch(tag, $sformatf("rd_addr %0d, expected %0d", rd_addr, rd));
	endtask

	task automatic check_word(input string tag, input word_t want);
		if (immediate !== want)
			mismatch(tag, $sformatf("immediate %h, expected %h", immediate, want));
	endtask

	task automatic check_csr(input string tag, input csr_addr_t addr, input csr_op_t op,
			input logic rena, input logic wena);
		if (csr_op !== op)
			mismatch(tag, $sformatf("csr_op %s, expected %s", csr_op.name(), op.name()));
		if (op != CSR_NONE && csr_addr !== addr)
			mismatch(tag, $sformatf("csr_addr %h, expected %h", csr_addr, addr));
		if ({csr_rena, csr_wena} !== {rena, wena})
			mismatch(tag, $sformatf("csr rena/wena %b%b, expected %b%b",
				csr_rena, csr_wena, rena, wena));
	endtask

	task automatic compare(input exp_t e, input string tag);
		check_ctrl(tag, e.alu, e.mem, e.wb, {e.valid, e.rs1_rena, e.rs2_rena, e.rd_wena,
			e.sel_pc, e.sel_im, e.jump_ena, e.jump_ind, e.jump_alw, e.env_call,
			e.trap_ret, e.illegal});
		check_regs(tag, e.rs1, e.rs2, e.rd, {e.rs1_rena, e.rs2_rena, e.rd_wena});
		check_word(tag, e.imm);
		check_csr(tag, e.csr_addr, e.csr_op, e.csr_rena, e.csr_wena);
	endtask

	// Drives one slot and checks the slot driven one cycle earlier.
	task automatic step(input logic v, input inst_t w, input exp_t e, input string tag);
		@(posedge clk);
		inst_valid <= v;
		inst       <= w;
		@(negedge clk);
		compare(prev, prev_tag);
		prev     = e;
		prev_tag = tag;
	endtask

	task automatic issue(input string tag, input inst_t w, input exp_t e);
		step(1'b1, w, e, tag);
	endtask

	task automatic idle();
		word_t r;
		exp_t  e;
		r = $random(seed); // A junk word on the bus must not leak through.
		e = '0;
		step(1'b0, r, e, "idle slot");
	endtask

	function automatic exp_t valid_exp(input inst_t w);
		exp_t e;
		e          = '0;
		e.valid    = 1'b1;
		e.rs1      = w[19:15];
		e.rs2      = w[24:20];
		e.rd       = w[11:7];
		e.csr_addr = w[31:20];
		return e;
	endfunction

	function automatic reg_addr_t nz(input reg_addr_t v);
		return (v == 5'd0) ? 5'd1 : v;
	endfunction

	task automatic alu_imm(input string tag, input logic [2:0] f3, input logic [11:0] imm,
			input alu_op_t op);
		word_t r;
		inst_t w;
		exp_t  e;
		r = $random(seed);
		w = {imm, r[4:0], f3, r[9:5], `OPC_OP_IMM};
		e = valid_exp(w);
		e.rs1_rena = 1'b1;
		e.rd_wena  = 1'b1;
		e.sel_im   = 1'b1;
		e.alu      = op;
		e.imm      = {{20{imm[11]}}, imm};
		issue(tag, w, e);
	endtask

	task automatic alu_reg(input string tag, input logic [6:0] f7, input logic [2:0] f3,
			input alu_op_t op);
		word_t r;
		inst_t w;
		exp_t  e;
		r = $random(seed);
		w = {f7, r[14:10], r[4:0], f3, r[9:5], `OPC_OP};
		e = valid_exp(w);
		e.rs1_rena = 1'b1;
		e.rs2_rena = 1'b1;
		e.rd_wena  = 1'b1;
		e.alu      = op;
		issue(tag, w, e);
	endtask

	task automatic mem_access(input string tag, input logic st, input logic [2:0] f3,
			input mem_op_t op);
		word_t       r;
		logic [11:0] imm;
		inst_t       w;
		exp_t        e;
		r   = $random(seed);
		imm = r[11:0];
		if (st)
			w = {imm[11:5], r[16:12], r[21:17], f3, imm[4:0], `OPC_STORE};
		else
			w = {imm, r[21:17], f3, r[26:22], `OPC_LOAD};
		e = valid_exp(w);
		e.rs1_rena = 1'b1;
		e.rs2_rena = st;
		e.rd_wena  = !st;
		e.sel_im   = 1'b1;
		e.wb       = WB_MEM;
		e.mem      = op;
		e.imm      = {{20{imm[11]}}, imm};
		issue(tag, w, e);
	endtask

	task automatic branch(input string tag, input logic [2:0] f3, input alu_op_t op);
		word_t       r;
		logic [12:0] off;
		inst_t       w;
		exp_t        e;
		r   = $random(seed);
		off = {r[11:0], 1'b0};
		w   = {off[12], off[10:5], r[16:12], r[21:17], f3, off[4:1], off[11], `OPC_BRANCH};
		e   = valid_exp(w);
		e.rs1_rena = 1'b1;
		e.rs2_rena = 1'b1;
		e.jump_ena = 1'b1;
		e.alu      = op;
		e.imm      = {{19{off[12]}}, off};
		issue(tag, w, e);
	endtask

	task automatic jump(input string tag, input logic ind);
		word_t       r;
		logic [20:0] off;
		word_t       imm;
		inst_t       w;
		exp_t        e;
		r = $random(seed);
		if (ind) begin
			w   = {r[11:0], r[16:12], `F3_JALR, r[24:20], `OPC_JALR};
			imm = {{20{r[11]}}, r[11:0]};
		end else begin
			off = {r[19:0], 1'b0};
			w   = {off[20], off[10:1], off[11], off[19:12], r[24:20], `OPC_JAL};
			imm = {{11{off[20]}}, off};
		end
		e = valid_exp(w);
		e.rs1_rena = ind;
		e.rd_wena  = 1'b1;
		e.sel_pc   = 1'b1;
		e.alu      = ALU_INC;
		e.jump_ena = 1'b1;
		e.jump_ind = ind;
		e.jump_alw = 1'b1;
		e.imm      = imm;
		issue(tag, w, e);
	endtask

	task automatic upper(input string tag, input logic auipc);
		word_t r;
		inst_t w;
		exp_t  e;
		r = $random(seed);
		w = {r[31:12], r[4:0], auipc ? `OPC_AUIPC : `OPC_LUI};
		e = valid_exp(w);
		e.rd_wena = 1'b1;
		e.sel_im  = 1'b1;
		e.sel_pc  = auipc;
		e.imm     = {r[31:12], 12'h000};
		issue(tag, w, e);
	endtask

	task automatic csr_inst(input logic [2:0] f3, input csr_op_t op, input reg_addr_t rd,
			input reg_addr_t src);
		word_t r;
		inst_t w;
		exp_t  e;
		r = $random(seed);
		w = {r[11:0], src, f3, rd, `OPC_SYSTEM};
		e = valid_exp(w);
		e.rd_wena  = 1'b1;
		e.wb       = WB_CSR;
		e.csr_op   = op;
		e.rs1_rena = !f3[2]; // funct3 bit 2 marks the uimm forms.
		e.sel_im   = f3[2];
		e.imm      = f3[2] ? {27'b0, src} : '0;
		e.csr_rena = (op == CSR_RW) ? (rd != 5'd0) : 1'b1;
		e.csr_wena = (op == CSR_RW) ? 1'b1 : (src != 5'd0);
		issue($sformatf("CSR f3=%0d rd=%0d src=%0d", f3, rd, src), w, e);
	endtask

	task automatic illegal_word(input string tag, input inst_t w);
		exp_t e;
		e         = '0;
		e.valid   = 1'b1;
		e.illegal = 1'b1;
		issue(tag, w, e);
	endtask

	task automatic after_reset();
		idle();
		idle();
	endtask

	task automatic alu_ops();
		word_t r;
		r = $random(seed);
		alu_imm("ADDI", `F3_ADD_SUB, r[11:0], ALU_ADD);
		alu_imm("ADDI negative", `F3_ADD_SUB, {1'b1, r[22:12]}, ALU_ADD);
		alu_imm("SLTIU", `F3_SLTU, r[23:12], ALU_SLTU);
		alu_imm("SRAI", `F3_SR, {`F7_ALT, r[28:24]}, ALU_SRA);
		alu_imm("XORI", `F3_XOR, r[31:20], ALU_XOR);
		alu_reg("ADD", `F7_BASE, `F3_ADD_SUB, ALU_ADD);
		alu_reg("SUB", `F7_ALT, `F3_ADD_SUB, ALU_SUB);
		alu_reg("SRA", `F7_ALT, `F3_SR, ALU_SRA);
		alu_reg("AND", `F7_BASE, `F3_AND, ALU_AND);
		idle();
	endtask

	task automatic mem_and_jumps();
		mem_access("LB", 1'b0, `F3_LB, MEM_LB);
		mem_access("LH", 1'b0, `F3_LH, MEM_LH);
		mem_access("LW", 1'b0, `F3_LW, MEM_LW);
		mem_access("LBU", 1'b0, `F3_LBU, MEM_LBU);
		mem_access("LHU", 1'b0, `F3_LHU, MEM_LHU);
		mem_access("SB", 1'b1, `F3_SB, MEM_SB);
		mem_access("SH", 1'b1, `F3_SH, MEM_SH);
		mem_access("SW", 1'b1, `F3_SW, MEM_SW);
		branch("BEQ", `F3_BEQ, ALU_SEQ);
		branch("BNE", `F3_BNE, ALU_SNE);
		branch("BLT", `F3_BLT, ALU_SLT);
		branch("BGE", `F3_BGE, ALU_SGE);
		branch("BLTU", `F3_BLTU, ALU_SLTU);
		branch("BGEU", `F3_BGEU, ALU_SGEU);
		jump("JAL", 1'b0);
		jump("JALR", 1'b1);
		upper("LUI", 1'b0);
		upper("AUIPC", 1'b1);
		idle();
	endtask

	task automatic csr_ops();
		logic [2:0] f3s [6];
		csr_op_t    ops [6];
		word_t      r;
		f3s = '{`F3_CSRRW, `F3_CSRRS, `F3_CSRRC, `F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI};
		ops = '{CSR_RW, CSR_RS, CSR_RC, CSR_RW, CSR_RS, CSR_RC};
		for (int i = 0; i < 6; i++) begin
			for (int k = 0; k < 4; k++) begin
				r = $random(seed); // k walks rd and the source through zero and nonzero.
				csr_inst(f3s[i], ops[i], k[0] ? nz(r[4:0]) : 5'd0, k[1] ? nz(r[9:5]) : 5'd0);
			end
		end
		idle();
	endtask

	task automatic system_ops();
		word_t r;
		exp_t  e;
		e = valid_exp(`INST_ECALL);
		e.env_call = 1'b1;
		issue("ECALL", `INST_ECALL, e);
		e = valid_exp(`INST_MRET);
		e.jump_ena = 1'b1;
		e.jump_alw = 1'b1;
		e.trap_ret = 1'b1;
		issue("MRET", `INST_MRET, e);
		issue("FENCE", 32'h0ff0000f, valid_exp(32'h0ff0000f));
		issue("WFI", `INST_WFI, valid_exp(`INST_WFI));
		illegal_word("EBREAK", `INST_EBREAK);
		r = $random(seed);
		illegal_word("reserved opcode", {r[31:7], 7'b1101011});
		idle();
	endtask

	task automatic back_to_back();
		mem_access("burst LW", 1'b0, `F3_LW, MEM_LW);
		alu_reg("burst SUB", `F7_ALT, `F3_ADD_SUB, ALU_SUB);
		csr_inst(`F3_CSRRSI, CSR_RS, 5'd3, 5'd17);
		branch("burst BLT", `F3_BLT, ALU_SLT);
		illegal_word("burst EBREAK", `INST_EBREAK);
		jump("burst JALR", 1'b1);
		idle();
		upper("burst AUIPC", 1'b1);
		mem_access("burst SH", 1'b1, `F3_SH, MEM_SH);
		alu_imm("burst XORI", `F3_XOR, 12'hf0f, ALU_XOR);
		idle();
		idle(); // dec_valid has to be low here.
	endtask

	initial begin
		rst        = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		prev       = '0;
		prev_tag   = "reset";
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		after_reset();
		alu_ops();
		mem_and_jumps();
		csr_ops();
		system_ops();
		back_to_back();
		@(posedge clk); // The last slot leaves the stage one cycle later.
		@(negedge clk);
		compare(prev, prev_tag);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: flist.f
+incdir+hw
hw/riscv_dec_pkg.sv
hw/decode_ctrl.sv
hw/imm_gen.sv
hw/csr_access.sv
hw/inst_decoder.sv
testbench/inst_decoder_asserts.sv
testbench/tb_inst_decoder.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_inst_decoder -f flist.f

# The simulator may exit nonzero on a failure; the search below decides the result.
output=$(./obj_dir/Vtb_inst_decoder 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
	exit 0
else
	echo "Simulation did not pass"
	exit 1
fi
